// ==== include/wsg_macros.svh ====
////////////////////////////////////////
// Sizes of the wavetable sound generator.
// Only WSG_VOICES and WSG_TICK_DIV may be changed; the address map
// assumes a 9-bit CPU address and 8-bit CPU data.
////////////////////////////////////////
`ifndef WSG_MACROS_SVH
`define WSG_MACROS_SVH

// Number of wavetable voices
`define WSG_VOICES 3

// Phase accumulator and frequency increment
`define WSG_ACC_W 20

// CPU port
`define WSG_ADDR_W 9
`define WSG_DATA_W 8

// Eight waveforms of 32 nibbles
`define WSG_WAVE_DEPTH 256
`define WSG_SMP_DEPTH 64

`define WSG_TICK_DIV 32
`define WSG_SND_W 10

`endif

// ==== design/wsgPkg.sv ====
////////////////////////////////////////
// Types shared by the sound generator.
// Widths follow wsg_macros.svh.
////////////////////////////////////////
`include "wsg_macros.svh"

package wsgPkg;

	// Per-voice register fields
	typedef logic [`WSG_ACC_W-1:0] freqT;
	typedef logic [3:0] volT;
	typedef logic [2:0] waveSelT;

	// Waveform number in the top bits, phase in the low five
	typedef logic [$clog2(`WSG_WAVE_DEPTH)-1:0] waveAddrT;
	typedef logic [3:0] nibbleT;

	// Nibble times volume
	typedef logic [7:0] voiceOutT;

	// Mixed output toward the DAC
	typedef logic [`WSG_SND_W-1:0] sndT;

endpackage

// ==== design/wsgRegFile.sv ====
////////////////////////////////////////
// CPU register file, waveform RAM and sample tick divider.
// One access per four-phase req/ack cycle; ack follows req by one clock.
////////////////////////////////////////
`timescale 1ns/1ps
`include "wsg_macros.svh"

module wsgRegFile (
	input  logic CCLK,
	input  logic arstN,
	input  logic cpuReq,
	input  logic cpuWrite,
	input  logic [`WSG_ADDR_W-1:0] cpuAddr,
	input  logic [`WSG_DATA_W-1:0] cpuWData,
	output logic cpuAck,
	output logic [`WSG_DATA_W-1:0] cpuRData,
	output wsgPkg::freqT [`WSG_VOICES-1:0] freq,
	output wsgPkg::volT [`WSG_VOICES-1:0] vol,
	output wsgPkg::waveSelT [`WSG_VOICES-1:0] waveSel,
	input  wsgPkg::waveAddrT [`WSG_VOICES-1:0] waveAddr,
	output wsgPkg::nibbleT [`WSG_VOICES-1:0] waveData,
	output logic tick,
	output logic enable,
	output logic bang,
	output logic smpWe,
	output logic [$clog2(`WSG_SMP_DEPTH)-1:0] smpAddr,
	output logic [`WSG_DATA_W-1:0] smpWData,
	input  logic [`WSG_DATA_W-1:0] smpRData
);
	localparam int DivW = $clog2(`WSG_TICK_DIV);

	logic access;
	logic wrAccess;
	logic isWave;
	logic isVoice;
	logic isCtrl;
	logic isBang;
	logic isSmp;
	logic [2:0] voiceIdx;
	logic [`WSG_DATA_W-1:0] rdMux;
	logic [DivW-1:0] divCnt;
	wsgPkg::nibbleT waveMem [`WSG_WAVE_DEPTH];

	// Access happens on the edge that raises ack
	assign access = cpuReq && !cpuAck;
	assign wrAccess = access && cpuWrite;

	assign voiceIdx = cpuAddr[4:2];
	assign isWave = (cpuAddr[8] == 1'b0);
	assign isVoice = (cpuAddr[8:5] == 4'b1000) && (voiceIdx < `WSG_VOICES);
	assign isCtrl = (cpuAddr == 9'h120);
	assign isBang = (cpuAddr == 9'h121);
	assign isSmp = (cpuAddr[8:6] == 3'b101);

	always_ff @(posedge CCLK or negedge arstN) begin
		if (!arstN) begin
			cpuAck <= 1'b0;
			cpuRData <= '0;
		end else begin
			cpuAck <= cpuReq;
			if (access && !cpuWrite)
				cpuRData <= rdMux;
		end
	end

	always_ff @(posedge CCLK or negedge arstN) begin
		if (!arstN) begin
			freq <= '0;
			vol <= '0;
			waveSel <= '0;
			enable <= 1'b0;
			bang <= 1'b0;
		end else begin
			bang <= wrAccess && isBang;
			if (wrAccess && isCtrl)
				enable <= cpuWData[0];
			if (wrAccess && isVoice) begin
				case (cpuAddr[1:0])
					2'd0: freq[voiceIdx][7:0] <= cpuWData;
					2'd1: freq[voiceIdx][15:8] <= cpuWData;
					2'd2: freq[voiceIdx][19:16] <= cpuWData[3:0];
					default: begin
						vol[voiceIdx] <= cpuWData[3:0];
						waveSel[voiceIdx] <= cpuWData[6:4];
					end
				endcase
			end
		end
	end

	always_ff @(posedge CCLK) begin
		if (wrAccess && isWave)
			waveMem[cpuAddr[7:0]] <= cpuWData[3:0];
	end

	// Bang and holes in the map read as zero
	always_comb begin
		rdMux = '0;
		if (isWave) begin
			rdMux[3:0] = waveMem[cpuAddr[7:0]];
		end else if (isVoice) begin
			case (cpuAddr[1:0])
				2'd0: rdMux = freq[voiceIdx][7:0];
				2'd1: rdMux = freq[voiceIdx][15:8];
				2'd2: rdMux[3:0] = freq[voiceIdx][19:16];
				default: rdMux[6:0] = {waveSel[voiceIdx], vol[voiceIdx]};
			endcase
		end else if (isCtrl) begin
			rdMux[0] = enable;
		end else if (isSmp) begin
			rdMux = smpRData;
		end
	end

	// Divider sits at zero until enable, first tick a full period later
	always_ff @(posedge CCLK or negedge arstN) begin
		if (!arstN) begin
			divCnt <= '0;
			tick <= 1'b0;
		end else if (!enable) begin
			divCnt <= '0;
			tick <= 1'b0;
		end else begin
			tick <= (divCnt == DivW'(`WSG_TICK_DIV - 1));
			if (divCnt == DivW'(`WSG_TICK_DIV - 1))
				divCnt <= '0;
			else
				divCnt <= divCnt + 1'b1;
		end
	end

	always_comb begin
		for (int v = 0; v < `WSG_VOICES; v++)
			waveData[v] = waveMem[waveAddr[v]];
	end

	assign smpWe = wrAccess && isSmp;
	assign smpAddr = cpuAddr[$bits(smpAddr)-1:0];
	assign smpWData = cpuWData;

endmodule

// ==== design/wsgVoice.sv ====
////////////////////////////////////////
// One wavetable voice.
// Output is valid two clocks after the tick that advanced the phase.
////////////////////////////////////////
`timescale 1ns/1ps
`include "wsg_macros.svh"

module wsgVoice (
	input  logic CCLK,
	input  logic arstN,
	input  logic enable,
	input  logic tick,
	input  wsgPkg::freqT freq,
	input  wsgPkg::volT vol,
	input  wsgPkg::waveSelT waveSel,
	output wsgPkg::waveAddrT waveAddr,
	input  wsgPkg::nibbleT waveData,
	output wsgPkg::voiceOutT out,
	output logic outValid
);
	wsgPkg::freqT acc;
	logic lookup;

	// Accumulator wraps at 2^20 and is held at zero while disabled
	always_ff @(posedge CCLK or negedge arstN) begin
		if (!arstN) begin
			acc <= '0;
			lookup <= 1'b0;
			outValid <= 1'b0;
		end else if (!enable) begin
			acc <= '0;
			lookup <= 1'b0;
			outValid <= 1'b0;
		end else begin
			lookup <= tick;
			outValid <= lookup;
			if (tick)
				acc <= acc + freq;
		end
	end

	// Top five phase bits pick the entry within the selected waveform
	assign waveAddr = {waveSel, acc[`WSG_ACC_W-1 -: 5]};

	always_ff @(posedge CCLK) begin
		if (lookup)
			out <= waveData * vol;
	end

endmodule

// ==== design/wsgSamplePlayer.sv ====
////////////////////////////////////////
// One-shot sample memory and player.
// A bang may be armed while disabled; playback waits for the first tick.
////////////////////////////////////////
`timescale 1ns/1ps
`include "wsg_macros.svh"

module wsgSamplePlayer (
	input  logic CCLK,
	input  logic arstN,
	input  logic enable,
	input  logic tick,
	input  logic bang,
	input  logic smpWe,
	input  logic [$clog2(`WSG_SMP_DEPTH)-1:0] smpAddr,
	input  logic [`WSG_DATA_W-1:0] smpWData,
	output logic [`WSG_DATA_W-1:0] smpRData,
	output logic [`WSG_DATA_W-1:0] out,
	output logic outValid
);
	localparam int PW = $clog2(`WSG_SMP_DEPTH);

	logic [`WSG_DATA_W-1:0] mem [`WSG_SMP_DEPTH];
	logic armed;
	logic playing;
	logic useSmp;
	logic lookup;
	logic [PW-1:0] pos;
	logic [PW-1:0] curIdx;

	always_ff @(posedge CCLK) begin
		if (smpWe)
			mem[smpAddr] <= smpWData;
	end

	assign smpRData = mem[smpAddr];

	always_ff @(posedge CCLK or negedge arstN) begin
		if (!arstN) begin
			armed <= 1'b0;
			playing <= 1'b0;
			useSmp <= 1'b0;
			lookup <= 1'b0;
			pos <= '0;
			curIdx <= '0;
			outValid <= 1'b0;
		end else if (!enable) begin
			// Armed state survives so a bang can precede enable
			armed <= armed || bang;
			playing <= 1'b0;
			useSmp <= 1'b0;
			lookup <= 1'b0;
			pos <= '0;
			outValid <= 1'b0;
		end else begin
			lookup <= tick;
			outValid <= lookup;
			if (tick) begin
				useSmp <= armed || playing;
				if (armed || playing) begin
					curIdx <= pos;
					if (!playing)
						armed <= 1'b0;
					if (pos == PW'(`WSG_SMP_DEPTH - 1)) begin
						playing <= 1'b0;
						pos <= '0;
					end else begin
						playing <= 1'b1;
						pos <= pos + 1'b1;
					end
				end
			end
			if (bang)
				armed <= 1'b1;
		end
	end

	// Idle level is mid-scale
	always_ff @(posedge CCLK) begin
		if (lookup)
			out <= useSmp ? mem[curIdx] : 8'd128;
	end

endmodule

// ==== design/wsgMixer.sv ====
////////////////////////////////////////
// Voice and sample mixer with the DAC-side four-phase handshake.
// A sum that finds the handshake busy is lost and sets overrun.
////////////////////////////////////////
`timescale 1ns/1ps
`include "wsg_macros.svh"

module wsgMixer (
	input  logic CCLK,
	input  logic arstN,
	input  logic enable,
	input  wsgPkg::voiceOutT [`WSG_VOICES-1:0] voiceOut,
	input  logic [`WSG_VOICES-1:0] voiceValid,
	input  logic [`WSG_DATA_W-1:0] smpOut,
	input  logic smpValid,
	output logic sndReq,
	output wsgPkg::sndT sndData,
	input  logic sndAck,
	output logic overrun
);
	wsgPkg::sndT sum;
	logic idle;
	logic sumReady;

	// Worst case 3 * 225 + 255 still fits in ten bits
	always_comb begin
		sum = wsgPkg::sndT'(smpOut);
		for (int v = 0; v < `WSG_VOICES; v++)
			sum = sum + wsgPkg::sndT'(voiceOut[v]);
	end

	assign idle = !sndReq && !sndAck;
	assign sumReady = smpValid || (|voiceValid);

	always_ff @(posedge CCLK or negedge arstN) begin
		if (!arstN) begin
			sndReq <= 1'b0;
			overrun <= 1'b0;
		end else begin
			if (sumReady && idle)
				sndReq <= 1'b1;
			else if (sndReq && sndAck)
				sndReq <= 1'b0;
			// Sticky until the CPU disables the generator
			if (!enable)
				overrun <= 1'b0;
			else if (sumReady && !idle)
				overrun <= 1'b1;
		end
	end

	always_ff @(posedge CCLK) begin
		if (sumReady && idle)
			sndData <= sum;
	end

endmodule

// ==== design/wsgSound.sv ====
////////////////////////////////////////
// Three-voice wavetable sound generator, top level.
// Waveform and sample memories are loaded by the CPU.
////////////////////////////////////////
`timescale 1ns/1ps
`include "wsg_macros.svh"

module wsgSound (
	input  logic CCLK,
	input  logic arstN,
	input  logic cpuReq,
	input  logic cpuWrite,
	input  logic [`WSG_ADDR_W-1:0] cpuAddr,
	input  logic [`WSG_DATA_W-1:0] cpuWData,
	output logic cpuAck,
	output logic [`WSG_DATA_W-1:0] cpuRData,
	output logic sndReq,
	output wsgPkg::sndT sndData,
	input  logic sndAck,
	output logic overrun
);
	wsgPkg::freqT [`WSG_VOICES-1:0] freq;
	wsgPkg::volT [`WSG_VOICES-1:0] vol;
	wsgPkg::waveSelT [`WSG_VOICES-1:0] waveSel;
	wsgPkg::waveAddrT [`WSG_VOICES-1:0] waveAddr;
	wsgPkg::nibbleT [`WSG_VOICES-1:0] waveData;
	wsgPkg::voiceOutT [`WSG_VOICES-1:0] voiceOut;
	logic [`WSG_VOICES-1:0] voiceValid;
	logic tick;
	logic enable;
	logic bang;
	logic smpWe;
	logic [$clog2(`WSG_SMP_DEPTH)-1:0] smpAddr;
	logic [`WSG_DATA_W-1:0] smpWData;
	logic [`WSG_DATA_W-1:0] smpRData;
	logic [`WSG_DATA_W-1:0] smpOut;
	logic smpValid;

	wsgRegFile i_regFile (
		.CCLK(CCLK),
		.arstN(arstN),
		.cpuReq(cpuReq),
		.cpuWrite(cpuWrite),
		.cpuAddr(cpuAddr),
		.cpuWData(cpuWData),
		.cpuAck(cpuAck),
		.cpuRData(cpuRData),
		.freq(freq),
		.vol(vol),
		.waveSel(waveSel),
		.waveAddr(waveAddr),
		.waveData(waveData),
		.tick(tick),
		.enable(enable),
		.bang(bang),
		.smpWe(smpWe),
		.smpAddr(smpAddr),
		.smpWData(smpWData),
		.smpRData(smpRData)
	);

	for (genvar v = 0; v < `WSG_VOICES; v++) begin : g_voice
		wsgVoice i_voice (
			.CCLK(CCLK),
			.arstN(arstN),
			.enable(enable),
			.tick(tick),
			.freq(freq[v]),
			.vol(vol[v]),
			.waveSel(waveSel[v]),
			.waveAddr(waveAddr[v]),
			.waveData(waveData[v]),
			.out(voiceOut[v]),
			.outValid(voiceValid[v])
		);
	end

	wsgSamplePlayer i_samplePlayer (
		.CCLK(CCLK),
		.arstN(arstN),
		.enable(enable),
		.tick(tick),
		.bang(bang),
		.smpWe(smpWe),
		.smpAddr(smpAddr),
		.smpWData(smpWData),
		.smpRData(smpRData),
		.out(smpOut),
		.outValid(smpValid)
	);

	wsgMixer i_mixer (
		.CCLK(CCLK),
		.arstN(arstN),
		.enable(enable),
		.voiceOut(voiceOut),
		.voiceValid(voiceValid),
		.smpOut(smpOut),
		.smpValid(smpValid),
		.sndReq(sndReq),
		.sndData(sndData),
		.sndAck(sndAck),
		.overrun(overrun)
	);

endmodule

// ==== test/wsgSound_chk.sv ====
////////////////////////////////////////
// Handshake and reset assertions.
// Bound into wsgSound with ports matched by name.
////////////////////////////////////////
`timescale 1ns/1ps

module wsgSound_chk (
	input logic CCLK,
	input logic arstN,
	input logic cpuReq,
	input logic cpuAck,
	input logic sndReq,
	input wsgPkg::sndT sndData,
	input logic sndAck,
	input logic overrun
);
	// Outputs idle while held in reset
	assert property (@(posedge CCLK) !arstN |-> !cpuAck && !sndReq && !overrun)
		else $error("handshake outputs active during reset");

	assert property (@(posedge CCLK) disable iff (!arstN)
		$past(sndReq) && sndReq |-> $stable(sndData))
		else $error("sndData changed while sndReq was held");

	assert property (@(posedge CCLK) disable iff (!arstN) $rose(sndAck) |-> sndReq)
		else $error("sndAck raised without sndReq");

	// A new request waits for the previous ack to drop
	assert property (@(posedge CCLK) disable iff (!arstN) $rose(cpuReq) |-> !cpuAck)
		else $error("cpuReq raised while cpuAck was still high");

endmodule

// ==== test/tbWsgSound.sv ====
////////////////////////////////////////
// Testbench for wsgSound that stops at the first mismatch.
// The row table assumes three voices.
////////////////////////////////////////
`timescale 1ns/1ps
`include "wsg_macros.svh"

module tbWsgSound;
	localparam int NumRows = 4;

	// Voice fields are written voice 2 first
	typedef struct packed {
		logic [`WSG_VOICES-1:0][19:0] freq;
		logic [`WSG_VOICES-1:0][3:0] vol;
		logic [`WSG_VOICES-1:0][2:0] sel;
		logic bang;
		logic [7:0] count;
		logic [7:0] delay;
	} rowT;

	logic CCLK;
	logic arstN;
	logic cpuReq;
	logic cpuWrite;
	logic [`WSG_ADDR_W-1:0] cpuAddr;
	logic [`WSG_DATA_W-1:0] cpuWData;
	logic cpuAck;
	logic [`WSG_DATA_W-1:0] cpuRData;
	logic sndReq;
	wsgPkg::sndT sndData;
	logic sndAck;
	logic overrun;

	logic [3:0] waveMdl [`WSG_WAVE_DEPTH];
	logic [7:0] smpMdl [`WSG_SMP_DEPTH];
	wsgPkg::sndT got [$];
	int ackDelay = 1;
	int cycles = 0;

	string names [NumRows] = '{"singleVoice", "threeVoices", "overrun", "bangOneShot"};
	rowT rows [NumRows] = '{
		'{{20'h00000, 20'h00000, 20'h08000}, {4'd0, 4'd0, 4'd15}, {3'd0, 3'd0, 3'd2},
			1'b0, 8'd40, 8'd1},
		'{{20'hF0001, 20'h1A2B3, 20'h0C351}, {4'd4, 4'd9, 4'd15}, {3'd7, 3'd5, 3'd1},
			1'b0, 8'd80, 8'd1},
		'{{20'h00000, 20'h00000, 20'h10000}, {4'd0, 4'd0, 4'd8}, {3'd0, 3'd0, 3'd3},
			1'b0, 8'd4, 8'd40},
		'{{20'h00000, 20'h00000, 20'h04000}, {4'd0, 4'd0, 4'd3}, {3'd0, 3'd0, 3'd0},
			1'b1, 8'd70, 8'd1}
	};

	wsgSound i_dut (.*);

	bind wsgSound wsgSound_chk i_chk (.*);

	initial CCLK = 1'b0;
	always #50 CCLK = ~CCLK;

	function automatic int timeoutCycles();
		int total;
		total = 2000;
		for (int r = 0; r < NumRows; r++)
			total += (int'(rows[r].count) + 4) * `WSG_TICK_DIV * 2;
		return total;
	endfunction

	// Expected k-th sample after enable with k from 1
	function automatic int expSample(int r, int k);
		logic [19:0] acc;
		int s;
		s = 0;
		for (int v = 0; v < `WSG_VOICES; v++) begin
			acc = 20'(k * int'(rows[r].freq[v]));
			s += int'(waveMdl[{rows[r].sel[v], acc[19:15]}]) * int'(rows[r].vol[v]);
		end
		if (rows[r].bang && k <= `WSG_SMP_DEPTH)
			s += int'(smpMdl[k - 1]);
		else
			s += 128;
		return s;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("[FAIL] %s expected %0d actual %0d", name, expected, actual);
			$display("CHECKS FAILED");
			$fatal(1, "value mismatch in %s", name);
		end
	endtask

	task automatic busAccess(input logic wr, input logic [8:0] addr, input logic [7:0] wdata,
			output logic [7:0] rdata);
		@(negedge CCLK);
		cpuReq = 1'b1;
		cpuWrite = wr;
		cpuAddr = addr;
		cpuWData = wdata;
		@(negedge CCLK);
		while (!cpuAck) @(negedge CCLK);
		rdata = cpuRData;
		cpuReq = 1'b0;
		@(negedge CCLK);
		while (cpuAck) @(negedge CCLK);
	endtask

	task automatic writeReg(input logic [8:0] addr, input logic [7:0] data);
		logic [7:0] unused;
		busAccess(1'b1, addr, data, unused);
	endtask

	task automatic checkRead(input string name, input logic [8:0] addr, input logic [7:0] exp);
		logic [7:0] d;
		busAccess(1'b0, addr, 8'h00, d);
		checkValue(name, exp, d);
	endtask

	always @(posedge CCLK) begin
		cycles++;
		if (cycles > timeoutCycles()) begin
			$display("Timeout: no result after %0d cycles", cycles);
			$display("CHECKS FAILED");
			$fatal(1, "simulation timed out");
		end
	end

	// DAC responder acks after the row's delay
	always begin
		@(negedge CCLK);
		if (sndReq && !sndAck) begin
			got.push_back(sndData);
			repeat (ackDelay) @(negedge CCLK);
			sndAck = 1'b1;
			@(negedge CCLK);
			while (sndReq) @(negedge CCLK);
			sndAck = 1'b0;
		end
	end

	initial begin
		logic [7:0] d;
		int a;
		void'($urandom(32'h27bcc968));
		arstN = 1'b0;
		cpuReq = 1'b0;
		cpuWrite = 1'b0;
		cpuAddr = '0;
		cpuWData = '0;
		sndAck = 1'b0;
		repeat (16) @(posedge CCLK);
		@(negedge CCLK);
		arstN = 1'b1;
		checkValue("reset.sndReq", 0, sndReq);
		checkValue("reset.cpuAck", 0, cpuAck);
		checkValue("reset.overrun", 0, overrun);

		for (int i = 0; i < `WSG_WAVE_DEPTH; i++) begin
			d = 8'($urandom);
			waveMdl[i] = d[3:0];
			writeReg(9'(i), d);
		end
		for (int i = 0; i < `WSG_SMP_DEPTH; i++) begin
			d = 8'($urandom);
			smpMdl[i] = d;
			writeReg(9'(9'h140 + i), d);
		end

		// Readback of registers and sampled memory locations
		for (int v = 0; v < `WSG_VOICES; v++) begin
			for (int i = 0; i < 4; i++) begin
				d = 8'($urandom);
				writeReg(9'(256 + 4 * v + i), d);
				if (i == 2)
					d = d & 8'h0F;
				else if (i == 3)
					d = d & 8'h7F;
				checkRead($sformatf("voice%0d.reg%0d", v, i), 9'(256 + 4 * v + i), d);
			end
		end
		writeReg(9'h120, 8'h01);
		checkRead("ctrl.on", 9'h120, 8'h01);
		writeReg(9'h120, 8'h00);
		checkRead("ctrl.off", 9'h120, 8'h00);
		for (int i = 0; i < 16; i++) begin
			a = $urandom_range(255);
			checkRead($sformatf("wave[%0d]", a), 9'(a), {4'h0, waveMdl[a]});
		end
		for (int i = 0; i < 8; i++) begin
			a = $urandom_range(63);
			checkRead($sformatf("smp[%0d]", a), 9'(9'h140 + a), smpMdl[a]);
		end
		checkRead("bang", 9'h121, 8'h00);
		checkRead("hole.voice3", 9'h10C, 8'h00);
		checkRead("hole.0x122", 9'h122, 8'h00);
		checkRead("hole.0x1FF", 9'h1FF, 8'h00);

		for (int r = 0; r < NumRows; r++) begin
			writeReg(9'h120, 8'h00);
			checkValue({names[r], ".overrunClear"}, 0, overrun);
			while (sndReq || sndAck) @(negedge CCLK);
			for (int v = 0; v < `WSG_VOICES; v++) begin
				writeReg(9'(256 + 4 * v), rows[r].freq[v][7:0]);
				writeReg(9'(257 + 4 * v), rows[r].freq[v][15:8]);
				writeReg(9'(258 + 4 * v), {4'h0, rows[r].freq[v][19:16]});
				writeReg(9'(259 + 4 * v), {1'b0, rows[r].sel[v], rows[r].vol[v]});
			end
			if (rows[r].bang)
				writeReg(9'h121, 8'h00);
			ackDelay = rows[r].delay;
			got.delete();
			writeReg(9'h120, 8'h01);
			if (rows[r].delay > `WSG_TICK_DIV) begin
				// Every second sample finds the handshake busy and is dropped
				while (got.size() < rows[r].count) @(negedge CCLK);
				checkValue({names[r], ".overrunSet"}, 1, overrun);
				for (int k = 1; k <= rows[r].count; k++)
					checkValue($sformatf("%s.k%0d", names[r], 2 * k - 1),
						expSample(r, 2 * k - 1), got[k - 1]);
			end else begin
				while (got.size() < rows[r].count) @(negedge CCLK);
				checkValue({names[r], ".overrun"}, 0, overrun);
				for (int k = 1; k <= rows[r].count; k++)
					checkValue($sformatf("%s.k%0d", names[r], k), expSample(r, k), got[k - 1]);
			end
		end
		writeReg(9'h120, 8'h00);
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+include
design/wsgPkg.sv
design/wsgRegFile.sv
design/wsgVoice.sv
design/wsgSamplePlayer.sv
design/wsgMixer.sv
design/wsgSound.sv
test/wsgSound_chk.sv
test/tbWsgSound.sv

// ==== Bender.yml ====
package:
  name: wsg_sound

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/wsgPkg.sv
      - design/wsgRegFile.sv
      - design/wsgVoice.sv
      - design/wsgSamplePlayer.sv
      - design/wsgMixer.sv
      - design/wsgSound.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/wsgSound_chk.sv
      - test/tbWsgSound.sv
